// File: Makefile
# Verilator build and run for the cpu front end testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cpu_frontend_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+hw
hw/isa_pkg.sv
hw/uop_pkg.sv
hw/opcode_decoder.sv
hw/uop_queue.sv
hw/uop_issue.sv
hw/cpu_frontend.sv
tb/cpu_frontend_tb.sv

// File: hw/cpu_frontend.sv
/*
 * cpu front end: decoder, micro-op queue and issue unit in a row.
 */
`include "cpu_settings.svh"

module cpu_frontend (
        input  logic                    clk,
        input  logic                    reset_n,
        input  logic                    byte_strobe,
        input  logic [`CPU_DATA_W-1:0]  byte_data,
        input  logic                    exec_stall,
        output logic                    fetch_hold,     // queue full level.
        output logic                    illegal,
        output logic                    issue,
        output uop_pkg::op_class_e      op_class,
        output logic                    write_a,
        output logic                    write_flags,
        output logic                    read_write,
        output uop_pkg::index_sel_e     index_sel,
        output logic                    imm_mode,
        output logic [`CPU_ADDR_W-1:0]  operand
);

        logic          uop_push;
        uop_pkg::uop_t uop_data;
        uop_pkg::uop_t head;
        logic          empty;
        logic          pop;

        opcode_decoder u_opcode_decoder (
                .clk         (clk),
                .reset_n     (reset_n),
                .byte_strobe (byte_strobe),
                .byte_data   (byte_data),
                .full        (fetch_hold),
                .uop_push    (uop_push),
                .uop_data    (uop_data),
                .illegal     (illegal)
        );

        uop_queue #(
                .payload_t (uop_pkg::uop_t),
                .DEPTH     (`CPU_QUEUE_DEPTH)
        ) u_uop_queue (
                .clk       (clk),
                .reset_n   (reset_n),
                .push      (uop_push),
                .push_data (uop_data),
                .pop       (pop),
                .head      (head),
                .full      (fetch_hold),
                .empty     (empty)
        );

        uop_issue u_uop_issue (
                .clk         (clk),
                .reset_n     (reset_n),
                .empty       (empty),
                .head        (head),
                .exec_stall  (exec_stall),
                .pop         (pop),
                .issue       (issue),
                .op_class    (op_class),
                .write_a     (write_a),
                .write_flags (write_flags),
                .read_write  (read_write),
                .index_sel   (index_sel),
                .imm_mode    (imm_mode),
                .operand     (operand)
        );

endmodule

// File: hw/cpu_settings.svh
/*
 * cpu front end settings: data and address widths, micro-op queue depth.
 */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////
`define CPU_DATA_W       8      // one program byte.
`define CPU_ADDR_W       16     // operand or absolute address.

////////////////////////////////////////////////////////////////////////////
// buffering
////////////////////////////////////////////////////////////////////////////
`define CPU_QUEUE_DEPTH  4      // micro-op entries between decode and issue.

`endif

// File: hw/isa_pkg.sv
/*
 * isa package: addressing-mode and operation fields of the 01 opcode group.
 */
package isa_pkg;

        // opcode layout is aaa_bbb_cc, cc selects the group.
        localparam logic [1:0] GROUP_01 = 2'b01;

        ////////////////////////////////////////////////////////////////////////////
        // addressing mode, opcode bits 4:2
        ////////////////////////////////////////////////////////////////////////////
        typedef enum logic [2:0] {
                am_x_ind = 3'b000,      // (zp,x).
                am_zpg   = 3'b001,
                am_imm   = 3'b010,
                am_abs   = 3'b011,
                am_ind_y = 3'b100,      // (zp),y.
                am_zpg_x = 3'b101,
                am_abs_y = 3'b110,
                am_abs_x = 3'b111
        } addr_mode_e;

        ////////////////////////////////////////////////////////////////////////////
        // operation, opcode bits 7:5
        ////////////////////////////////////////////////////////////////////////////
        typedef enum logic [2:0] {
                op_ora = 3'b000,
                op_and = 3'b001,
                op_eor = 3'b010,
                op_adc = 3'b011,
                op_sta = 3'b100,        // no immediate form.
                op_lda = 3'b101,
                op_cmp = 3'b110,
                op_sbc = 3'b111
        } op_code_e;

endpackage

// File: hw/opcode_decoder.sv
/*
 * opcode decoder: collects an opcode and its operand bytes from the
 * byte stream and emits one decoded micro-op per instruction.
 */
`include "cpu_settings.svh"

module opcode_decoder (
        input  logic                   clk,
        input  logic                   reset_n,
        input  logic                   byte_strobe,
        input  logic [`CPU_DATA_W-1:0] byte_data,
        input  logic                   full,
        output logic                   uop_push,
        output uop_pkg::uop_t          uop_data,
        output logic                   illegal
);

        logic                   busy;           // operand bytes pending.
        logic [1:0]             fetch_count;
        logic [1:0]             fetch_target;
        logic [1:0]             next_count;
        isa_pkg::op_code_e      op_q;
        isa_pkg::addr_mode_e    mode_q;
        logic [`CPU_DATA_W-1:0] operand_lo;

        logic                   accept;
        logic                   last_byte;
        isa_pkg::op_code_e      byte_op;
        isa_pkg::addr_mode_e    byte_mode;
        logic                   byte_legal;

        // absolute forms carry two operand bytes.
        function automatic logic [1:0] target_of(input isa_pkg::addr_mode_e mode);
                case (mode)
                        isa_pkg::am_abs,
                        isa_pkg::am_abs_y,
                        isa_pkg::am_abs_x: return 2'd2;
                        default:           return 2'd1;
                endcase
        endfunction

        function automatic uop_pkg::index_sel_e index_of(input isa_pkg::addr_mode_e mode);
                case (mode)
                        isa_pkg::am_zpg_x,
                        isa_pkg::am_abs_x: return uop_pkg::idx_x;
                        isa_pkg::am_ind_y,
                        isa_pkg::am_abs_y: return uop_pkg::idx_y;
                        default:           return uop_pkg::idx_none;
                endcase
        endfunction

        assign accept     = byte_strobe && !full;       // hold drops the byte.
        assign byte_op    = isa_pkg::op_code_e'(byte_data[7:5]);
        assign byte_mode  = isa_pkg::addr_mode_e'(byte_data[4:2]);
        assign byte_legal = (byte_data[1:0] == isa_pkg::GROUP_01) &&
                            !(byte_op == isa_pkg::op_sta && byte_mode == isa_pkg::am_imm);
        assign next_count = fetch_count + 2'd1;
        assign last_byte  = accept && busy && (next_count == fetch_target);

        ////////////////////////////////////////////////////////////////////////////
        // fetch control
        ////////////////////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        busy         <= 1'b0;
                        fetch_count  <= 2'd0;
                        fetch_target <= 2'd0;
                        uop_push     <= 1'b0;
                        illegal      <= 1'b0;
                end else begin
                        uop_push <= 1'b0;
                        illegal  <= 1'b0;
                        if (accept && !busy) begin
                                if (byte_legal) begin
                                        busy         <= 1'b1;
                                        fetch_count  <= 2'd0;
                                        fetch_target <= target_of(byte_mode);
                                end else begin
                                        illegal <= 1'b1;        // opcode dropped.
                                end
                        end else if (accept) begin
                                fetch_count <= next_count;
                                if (last_byte) begin
                                        busy     <= 1'b0;
                                        uop_push <= 1'b1;
                                end
                        end
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // opcode fields and operand assembly
        ////////////////////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (accept && !busy) begin
                        op_q   <= byte_op;
                        mode_q <= byte_mode;
                end
                if (accept && busy && fetch_count == 2'd0)
                        operand_lo <= byte_data;        // low byte first.
                if (last_byte) begin
                        uop_data.op          <= op_q;
                        uop_data.mode        <= mode_q;
                        uop_data.index       <= index_of(mode_q);
                        uop_data.write_a     <= (op_q != isa_pkg::op_sta) &&
                                                (op_q != isa_pkg::op_cmp);
                        uop_data.write_flags <= (op_q != isa_pkg::op_sta);
                        uop_data.mem_write   <= (op_q == isa_pkg::op_sta);
                        if (fetch_count == 2'd0)
                                uop_data.operand <= `CPU_ADDR_W'(byte_data);
                        else
                                uop_data.operand <= {byte_data, operand_lo};
                end
        end

        // the source waits out hold before strobing.
        a_no_strobe_on_hold: assert property (@(posedge clk) disable iff (!reset_n)
                byte_strobe |-> !full)
                else $error("opcode_decoder: byte strobe while queue full");

        a_push_not_full: assert property (@(posedge clk) disable iff (!reset_n)
                uop_push |-> !full)
                else $error("opcode_decoder: push into full queue");

endmodule

// File: hw/uop_issue.sv
/*
 * issue unit: pops one micro-op at a time and drives a single cycle
 * of registered control outputs for it.
 */
`include "cpu_settings.svh"

module uop_issue (
        input  logic                    clk,
        input  logic                    reset_n,
        input  logic                    empty,
        input  uop_pkg::uop_t           head,
        input  logic                    exec_stall,
        output logic                    pop,
        output logic                    issue,
        output uop_pkg::op_class_e      op_class,
        output logic                    write_a,
        output logic                    write_flags,
        output logic                    read_write,     // low writes memory.
        output uop_pkg::index_sel_e     index_sel,
        output logic                    imm_mode,
        output logic [`CPU_ADDR_W-1:0]  operand
);

        function automatic uop_pkg::op_class_e class_of(input isa_pkg::op_code_e op);
                case (op)
                        isa_pkg::op_adc,
                        isa_pkg::op_sbc: return uop_pkg::cls_arith;
                        isa_pkg::op_cmp: return uop_pkg::cls_compare;
                        isa_pkg::op_lda: return uop_pkg::cls_load;
                        isa_pkg::op_sta: return uop_pkg::cls_store;
                        default:         return uop_pkg::cls_logic;
                endcase
        endfunction

        assign pop = !empty && !exec_stall;

        // fields idle at zero with read_write high between issues.
        always_ff @(posedge clk) begin
                if (!reset_n || !pop) begin
                        issue       <= 1'b0;
                        op_class    <= uop_pkg::cls_logic;
                        write_a     <= 1'b0;
                        write_flags <= 1'b0;
                        read_write  <= 1'b1;
                        index_sel   <= uop_pkg::idx_none;
                        imm_mode    <= 1'b0;
                        operand     <= '0;
                end else begin
                        issue       <= 1'b1;
                        op_class    <= class_of(head.op);
                        write_a     <= head.write_a;
                        write_flags <= head.write_flags;
                        read_write  <= !head.mem_write;
                        index_sel   <= head.index;
                        imm_mode    <= (head.mode == isa_pkg::am_imm);
                        operand     <= head.operand;
                end
        end

        // a stalled head stays put and nothing issues.
        a_stall_keeps_head: assert property (@(posedge clk) disable iff (!reset_n)
                exec_stall && !empty |=> !issue && !empty && $stable(head))
                else $error("uop_issue: record lost or issued under stall");

endmodule

// File: hw/uop_pkg.sv
/*
 * micro-op package: decoded record passed from the decoder to issue.
 */
`include "cpu_settings.svh"

package uop_pkg;

        typedef enum logic [1:0] {
                cls_logic = 2'd0,
                cls_arith = 2'd1,
                cls_load  = 2'd2,
                cls_store = 2'd3
        } op_class_e;

        // compare runs through the adder, write enables tell it apart.
        localparam op_class_e cls_compare = cls_arith;

        typedef enum logic [1:0] {
                idx_none = 2'd0,
                idx_x    = 2'd1,
                idx_y    = 2'd2
        } index_sel_e;

        typedef struct packed {
                isa_pkg::op_code_e      op;
                isa_pkg::addr_mode_e    mode;
                index_sel_e             index;
                logic                   write_a;        // accumulator update.
                logic                   write_flags;
                logic                   mem_write;      // sta only.
                logic [`CPU_ADDR_W-1:0] operand;        // little endian.
        } uop_t;

endpackage

// File: hw/uop_queue.sv
/*
 * micro-op queue: circular FIFO with a type-parameter payload.
 */
module uop_queue #(
        parameter type payload_t = logic [7:0],
        parameter int  DEPTH     = 4
) (
        input  logic     clk,
        input  logic     reset_n,
        input  logic     push,
        input  payload_t push_data,
        input  logic     pop,
        output payload_t head,
        output logic     full,
        output logic     empty
);

        localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int CNT_W = $clog2(DEPTH + 1);

        payload_t         mem [DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;

        // wraps for any depth, not only powers of two.
        function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
                return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        endfunction

        assign head  = mem[rd_ptr];
        assign full  = (count == CNT_W'(DEPTH));
        assign empty = (count == '0);

        always_ff @(posedge clk) begin
                if (push)
                        mem[wr_ptr] <= push_data;
        end

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push)
                                wr_ptr <= ptr_next(wr_ptr);
                        if (pop)
                                rd_ptr <= ptr_next(rd_ptr);
                        case ({push, pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;        // both or neither.
                        endcase
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // protocol checks
        ////////////////////////////////////////////////////////////////////////////
        a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
                push |-> !full)
                else $error("uop_queue: push while full");

        a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
                pop |-> !empty)
                else $error("uop_queue: pop while empty");

endmodule

// File: tb/cpu_frontend_tb.sv
/*
 * cpu front end testbench: table of instructions sent as a byte stream,
 * issue and illegal pulses checked against expected decode results.
 */
`include "cpu_settings.svh"

module cpu_frontend_tb;

        localparam int num_rows        = 23;
        localparam int watchdog_cycles = num_rows * 60;

        // expected encodings of the issue fields.
        localparam int c_log = int'(uop_pkg::cls_logic);
        localparam int c_ari = int'(uop_pkg::cls_arith);
        localparam int c_lod = int'(uop_pkg::cls_load);
        localparam int c_sto = int'(uop_pkg::cls_store);
        localparam int i_no  = int'(uop_pkg::idx_none);
        localparam int i_x   = int'(uop_pkg::idx_x);
        localparam int i_y   = int'(uop_pkg::idx_y);

        logic                    clk;
        logic                    reset_n;
        logic                    byte_strobe;
        logic [`CPU_DATA_W-1:0]  byte_data;
        logic                    exec_stall;
        logic                    fetch_hold;
        logic                    illegal;
        logic                    issue;
        uop_pkg::op_class_e      op_class;
        logic                    write_a;
        logic                    write_flags;
        logic                    read_write;
        uop_pkg::index_sel_e     index_sel;
        logic                    imm_mode;
        logic [`CPU_ADDR_W-1:0]  operand;

        // one row per test.
        string names     [num_rows];
        int    nbytes    [num_rows];
        int    row_bytes [num_rows][3];
        int    stall_len [num_rows];    // 0 drain first, -1 back to back, >0 stall cycles.
        int    exp_ill   [num_rows];
        int    exp_cls   [num_rows];
        int    exp_flags [num_rows];    // {write_a, write_flags, read_write}.
        int    exp_idx   [num_rows];
        int    exp_imm   [num_rows];
        int    exp_opnd  [num_rows];
        int    check_lat [num_rows];
        int    strobe_at [num_rows];
        int    row_err   [num_rows];

        int    issue_row_q [$];
        int    ill_row_q   [$];
        int    row_count;
        int    cycle_count;
        int    sent_legal;
        int    errors;
        int    tests_passed;
        int    tests_failed;
        int    mon_row;

        cpu_frontend u_cpu_frontend (
                .clk         (clk),
                .reset_n     (reset_n),
                .byte_strobe (byte_strobe),
                .byte_data   (byte_data),
                .exec_stall  (exec_stall),
                .fetch_hold  (fetch_hold),
                .illegal     (illegal),
                .issue       (issue),
                .op_class    (op_class),
                .write_a     (write_a),
                .write_flags (write_flags),
                .read_write  (read_write),
                .index_sel   (index_sel),
                .imm_mode    (imm_mode),
                .operand     (operand)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        always @(posedge clk)
                cycle_count <= cycle_count + 1;

        ////////////////////////////////////////////////////////////////////////////
        // table and helpers
        ////////////////////////////////////////////////////////////////////////////
        task automatic add_row(input string nm, input int n, input int b0, input int b1,
                               input int b2, input int stall, input int ill, input int cls,
                               input int flags, input int idx, input int imm, input int opnd);
                names[row_count]        = nm;
                nbytes[row_count]       = n;
                row_bytes[row_count][0] = b0;
                row_bytes[row_count][1] = b1;
                row_bytes[row_count][2] = b2;
                stall_len[row_count]    = stall;
                exp_ill[row_count]      = ill;
                exp_cls[row_count]      = cls;
                exp_flags[row_count]    = flags;
                exp_idx[row_count]      = idx;
                exp_imm[row_count]      = imm;
                exp_opnd[row_count]     = opnd;
                check_lat[row_count]    = (stall == 0 && ill == 0) ? 1 : 0;
                row_err[row_count]      = 0;
                row_count++;
        endtask

        task automatic fill_table();
                add_row("lda_imm",   2, 'hA9, 'h42, 'h00,  0, 0, c_lod, 'b111, i_no, 1, 'h0042);
                add_row("ora_x_ind", 2, 'h01, 'h10, 'h00,  0, 0, c_log, 'b111, i_no, 0, 'h0010);
                add_row("ora_zpg",   2, 'h05, 'h20, 'h00,  0, 0, c_log, 'b111, i_no, 0, 'h0020);
                add_row("ora_imm",   2, 'h09, 'h33, 'h00,  0, 0, c_log, 'b111, i_no, 1, 'h0033);
                add_row("ora_abs",   3, 'h0D, 'h34, 'h12,  0, 0, c_log, 'b111, i_no, 0, 'h1234);
                add_row("ora_ind_y", 2, 'h11, 'h44, 'h00,  0, 0, c_log, 'b111, i_y,  0, 'h0044);
                add_row("ora_zpg_x", 2, 'h15, 'h55, 'h00,  0, 0, c_log, 'b111, i_x,  0, 'h0055);
                add_row("ora_abs_y", 3, 'h19, 'h78, 'h56,  0, 0, c_log, 'b111, i_y,  0, 'h5678);
                add_row("ora_abs_x", 3, 'h1D, 'hBC, 'h9A,  0, 0, c_log, 'b111, i_x,  0, 'h9ABC);
                add_row("sta_zpg",   2, 'h85, 'h80, 'h00,  0, 0, c_sto, 'b000, i_no, 0, 'h0080);
                add_row("sta_abs",   3, 'h8D, 'h00, 'h02,  0, 0, c_sto, 'b000, i_no, 0, 'h0200);
                add_row("cmp_imm",   2, 'hC9, 'h7F, 'h00,  0, 0, c_ari, 'b011, i_no, 1, 'h007F);
                add_row("bad_group", 1, 'hA2, 'h00, 'h00,  0, 1, 0,     0,     0,    0, 0);
                add_row("lda_next",  2, 'hA9, 'h01, 'h00, -1, 0, c_lod, 'b111, i_no, 1, 'h0001);
                add_row("sta_imm",   1, 'h89, 'h00, 'h00,  0, 1, 0,     0,     0,    0, 0);
                add_row("and_next",  2, 'h25, 'h0F, 'h00, -1, 0, c_log, 'b111, i_no, 0, 'h000F);
                add_row("adc_stall", 3, 'h6D, 'h11, 'h22, 40, 0, c_ari, 'b111, i_no, 0, 'h2211);
                add_row("sbc_imm",   2, 'hE9, 'h05, 'h00, -1, 0, c_ari, 'b111, i_no, 1, 'h0005);
                add_row("eor_imm",   2, 'h49, 'hAA, 'h00, -1, 0, c_log, 'b111, i_no, 1, 'h00AA);
                add_row("lda_abs_x", 3, 'hBD, 'h00, 'h30, -1, 0, c_lod, 'b111, i_x,  0, 'h3000);
                add_row("sta_abs_y", 3, 'h99, 'h34, 'h12, -1, 0, c_sto, 'b000, i_y,  0, 'h1234);
                add_row("cmp_zpg_x", 2, 'hD5, 'h66, 'h00, -1, 0, c_ari, 'b011, i_x,  0, 'h0066);
                add_row("lda_zpg",   2, 'hA5, 'h07, 'h00,  0, 0, c_lod, 'b111, i_no, 0, 'h0007);
        endtask

        task automatic compare_field(input int r, input string field, input int expv,
                                     input int actv);
                assert (expv == actv) else begin
                        $display("Mismatch test %s %s expected 'h%0h actual 'h%0h",
                                 names[r], field, expv, actv);
                        errors++;
                        row_err[r]++;
                end
        endtask

        task automatic finish_test(input int r);
                if (row_err[r] == 0) begin
                        tests_passed++;
                        $display("test %s: ok", names[r]);
                end else begin
                        tests_failed++;
                        $display("test %s: %0d error(s)", names[r], row_err[r]);
                end
        endtask

        // waits out fetch_hold, one strobe cycle per byte.
        task automatic send_byte(input int b, output int at);
                while (fetch_hold)
                        @(negedge clk);
                byte_strobe = 1'b1;
                byte_data   = 8'(b);
                at          = cycle_count;
                @(negedge clk);
                byte_strobe = 1'b0;
        endtask

        task automatic wait_drain();
                while (issue_row_q.size() != 0 || ill_row_q.size() != 0)
                        @(negedge clk);
        endtask

        task automatic hold_exec(input int r, input int len);
                int base;
                int seen;
                int i;
                base       = sent_legal;
                seen       = 0;
                exec_stall = 1'b1;
                for (i = 0; i < len; i++) begin
                        @(negedge clk);
                        if (fetch_hold && seen == 0) begin
                                seen = 1;
                                compare_field(r, "records_at_hold", `CPU_QUEUE_DEPTH,
                                              sent_legal - base);
                        end
                end
                exec_stall = 1'b0;
                assert (seen == 1) else begin
                        $display("fetch_hold never rose while exec_stall was held in test %s",
                                 names[r]);
                        errors++;
                        row_err[r]++;
                end
        endtask

        task automatic apply_row(input int r);
                int i;
                int at;
                if (stall_len[r] >= 0)
                        wait_drain();
                if (exp_ill[r] != 0)
                        ill_row_q.push_back(r);
                else
                        issue_row_q.push_back(r);
                if (stall_len[r] > 0) begin
                        fork
                                hold_exec(r, stall_len[r]);
                        join_none
                end
                for (i = 0; i < nbytes[r]; i++) begin
                        if (i > 0)
                                repeat ($urandom % 2) @(negedge clk);
                        send_byte(row_bytes[r][i], at);
                end
                strobe_at[r] = at;      // last byte.
                if (exp_ill[r] == 0)
                        sent_legal++;
                repeat ($urandom % 2) @(negedge clk);
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // monitor
        ////////////////////////////////////////////////////////////////////////////
        always @(negedge clk) begin
                if (reset_n) begin
                        if (issue) begin
                                assert (issue_row_q.size() != 0) else begin
                                        $display("issue pulse arrived with no record pending");
                                        errors++;
                                end
                                if (issue_row_q.size() != 0) begin
                                        mon_row = issue_row_q.pop_front();
                                        compare_field(mon_row, "op_class", exp_cls[mon_row],
                                                      int'(op_class));
                                        compare_field(mon_row, "write_a",
                                                      (exp_flags[mon_row] >> 2) & 1,
                                                      int'(write_a));
                                        compare_field(mon_row, "write_flags",
                                                      (exp_flags[mon_row] >> 1) & 1,
                                                      int'(write_flags));
                                        compare_field(mon_row, "read_write",
                                                      exp_flags[mon_row] & 1,
                                                      int'(read_write));
                                        compare_field(mon_row, "index_sel", exp_idx[mon_row],
                                                      int'(index_sel));
                                        compare_field(mon_row, "imm_mode", exp_imm[mon_row],
                                                      int'(imm_mode));
                                        compare_field(mon_row, "operand", exp_opnd[mon_row],
                                                      int'(operand));
                                        if (check_lat[mon_row] != 0)
                                                compare_field(mon_row, "latency", 3,
                                                              cycle_count - strobe_at[mon_row]);
                                        finish_test(mon_row);
                                end
                        end
                        if (illegal) begin
                                assert (ill_row_q.size() != 0) else begin
                                        $display("illegal pulse arrived for a legal opcode");
                                        errors++;
                                end
                                if (ill_row_q.size() != 0)
                                        finish_test(ill_row_q.pop_front());
                        end
                end
        end

        initial begin
                repeat (watchdog_cycles) @(posedge clk);
                $display("watchdog: issue outputs stopped arriving after %0d cycles",
                         watchdog_cycles);
                $display("TEST FAIL");
                $finish;
        end

        ////////////////////////////////////////////////////////////////////////////
        // main sequence
        ////////////////////////////////////////////////////////////////////////////
        initial begin
                int r;
                reset_n      = 1'b0;
                byte_strobe  = 1'b0;
                byte_data    = '0;
                exec_stall   = 1'b0;
                row_count    = 0;
                cycle_count  = 0;
                sent_legal   = 0;
                errors       = 0;
                tests_passed = 0;
                tests_failed = 0;
                void'($urandom(32'h5dde));
                fill_table();
                repeat (10) @(negedge clk);
                reset_n = 1'b1;
                assert (!fetch_hold && !issue && !illegal) else begin
                        $display("outputs not idle after reset");
                        errors++;
                end
                for (r = 0; r < num_rows; r++)
                        apply_row(r);
                wait_drain();
                repeat (8) @(negedge clk);      // catch stray pulses.
                $display("tests %0d, passed %0d, failed %0d, errors %0d",
                         num_rows, tests_passed, tests_failed, errors);
                if (errors == 0 && tests_passed == num_rows)
                        $display("TEST PASS");
                else
                        $display("TEST FAIL");
                $finish;
        end

endmodule
